// ==== fetch_unit.f ====
hw/fetch_pkg.sv
hw/fetch_pc.sv
hw/if_stage.sv
hw/fetch_top.sv
verification/fetch_sva.sv
verification/fetch_tb.sv

// ==== hw/fetch_pc.sv ====
////////////////////////////////////////////////////////////
// Fetch program counter generator
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
	input  wire                  clk,
	input  wire                  rst_n_i,
	// Pipeline control
	input  wire                  freeze_i,
	input  wire                  flush_i,
	input  wire [31:0]           flush_pc_i,
	// Back from the fetch stage
	input  wire                  if_stall_i,
	// Cache request
	output fetch_pkg::icpu_req_t icpu_req_o
);

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	// Stage moves on when not frozen and a response is at hand
	logic        advance;
	// Fetch address register and its next value
	logic [31:0] addr_q;
	logic [31:0] addr_d;
	// Request valid, low only through reset
	logic        valid_q;

	assign advance = !freeze_i && !if_stall_i;

	////////////////////////////////////////////////////////////
	// Next address
	////////////////////////////////////////////////////////////

	always_comb begin
		// Hold by default, address stays stable for the cache
		addr_d = addr_q;
		if (flush_i) begin
			// Redirect wins over everything else
			addr_d = {flush_pc_i[31:2], 2'b00};
		end else if (advance) begin
			// Sequential step
			addr_d = addr_q + fetch_pkg::PC_STEP;
		end
	end

	////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////

	// Address loads the boot vector in reset
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			addr_q <= fetch_pkg::RESET_PC;
		end else begin
			addr_q <= addr_d;
		end
	end

	// Valid rises on the first cycle out of reset and then stays
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Request out
	////////////////////////////////////////////////////////////

	// Low two bits forced to zero, word fetch only
	assign icpu_req_o.valid = valid_q;
	assign icpu_req_o.addr  = {addr_q[31:2], 2'b00};

endmodule

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
////////////////////////////////////////////////////////////
// Fetch subsystem shared types and constants
////////////////////////////////////////////////////////////

`default_nettype none

package fetch_pkg;

	// First fetch address after reset
	localparam logic [31:0] RESET_PC = 32'h0000_0100;

	// Sequential fetch step, one word
	localparam logic [31:0] PC_STEP = 32'd4;

	// Killed or replaced slot
	localparam logic [31:0] NOP_INSN = {6'b000101, 26'h041_0000};

	// Stall filler while the cache has not answered
	localparam logic [31:0] NOP_EMPTY = {6'b000101, 26'h061_0000};

	// Error tags from the instruction cache
	typedef enum logic [3:0] {
		ITAG_NONE = 4'h0,
		ITAG_BE   = 4'hb,
		ITAG_PE   = 4'hc,
		ITAG_TE   = 4'hd
	} itag_e;

	// Fetch exceptions handed to decode
	typedef enum logic [1:0] {
		EXC_NONE       = 2'd0,
		EXC_ITLB_MISS  = 2'd1,
		EXC_IMMU_FAULT = 2'd2,
		EXC_IBUS_ERR   = 2'd3
	} exc_e;

	// Request toward the cache
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} icpu_req_t;

	// Response from the cache, valid only with ack or err
	typedef struct packed {
		logic        ack;
		logic        err;
		logic [31:0] data;
		itag_e       tag;
	} icpu_rsp_t;

	// Fetch stage result toward decode
	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] pc;
		exc_e        exc;
	} if_out_t;

endpackage

`default_nettype wire

// ==== hw/fetch_top.sv ====
////////////////////////////////////////////////////////////
// Fetch subsystem top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  wire                  clk,
	input  wire                  rst_n_i,
	// Instruction cache port
	output fetch_pkg::icpu_req_t icpu_req_o,
	input  fetch_pkg::icpu_rsp_t icpu_rsp_i,
	// Pipeline control
	input  wire                  freeze_i,
	input  wire                  flush_i,
	input  wire [31:0]           flush_pc_i,
	input  wire                  no_more_dslot_i,
	input  wire                  rfe_i,
	// Toward decode
	output fetch_pkg::if_out_t   if_out_o,
	output logic                 if_stall_o
);

	////////////////////////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////////////////////////

	// Request shared by the cache and the fetch stage
	fetch_pkg::icpu_req_t icpu_req;
	// Stall fed back to the PC generator
	logic                 if_stall;

	assign icpu_req_o = icpu_req;
	assign if_stall_o = if_stall;

	////////////////////////////////////////////////////////////
	// PC generator
	////////////////////////////////////////////////////////////

	fetch_pc u_fetch_pc (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.freeze_i   (freeze_i),
		.flush_i    (flush_i),
		.flush_pc_i (flush_pc_i),
		.if_stall_i (if_stall),
		.icpu_req_o (icpu_req)
	);

	////////////////////////////////////////////////////////////
	// Fetch stage
	////////////////////////////////////////////////////////////

	// Consumes the cache answer for the current request
	if_stage u_if_stage (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.req_i           (icpu_req),
		.rsp_i           (icpu_rsp_i),
		.freeze_i        (freeze_i),
		.flush_i         (flush_i),
		.no_more_dslot_i (no_more_dslot_i),
		.rfe_i           (rfe_i),
		.if_out_o        (if_out_o),
		.if_stall_o      (if_stall)
	);

endmodule

`default_nettype wire

// ==== hw/if_stage.sv ====
////////////////////////////////////////////////////////////
// Instruction fetch stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module if_stage (
	input  wire                  clk,
	input  wire                  rst_n_i,
	// Current fetch request
	input  fetch_pkg::icpu_req_t req_i,
	// Cache response
	input  fetch_pkg::icpu_rsp_t rsp_i,
	// Pipeline control
	input  wire                  freeze_i,
	input  wire                  flush_i,
	input  wire                  no_more_dslot_i,
	input  wire                  rfe_i,
	// Toward decode
	output fetch_pkg::if_out_t   if_out_o,
	output logic                 if_stall_o
);

	// Tag to exception, only meaningful on err
	function automatic fetch_pkg::exc_e tag_to_exc(input fetch_pkg::itag_e tag);
		fetch_pkg::exc_e exc;
		case (tag)
			fetch_pkg::ITAG_TE: exc = fetch_pkg::EXC_ITLB_MISS;
			fetch_pkg::ITAG_PE: exc = fetch_pkg::EXC_IMMU_FAULT;
			fetch_pkg::ITAG_BE: exc = fetch_pkg::EXC_IBUS_ERR;
			default:            exc = fetch_pkg::EXC_NONE;
		endcase
		return exc;
	endfunction

	////////////////////////////////////////////////////////////
	// Response decode
	////////////////////////////////////////////////////////////

	// Any answer from the cache this cycle
	logic            rsp_vld;
	// Exception carried by the live response
	fetch_pkg::exc_e live_exc;
	// Bypass state and its live view
	logic            bypass_q;
	logic            bypass;
	// Saved entry
	logic            saved_q;
	logic            save_insn;
	logic [31:0]     insn_saved_q;
	logic [31:0]     pc_saved_q;
	fetch_pkg::exc_e exc_saved_q;
	// Aligned request address
	logic [31:0]     req_pc;

	assign rsp_vld  = rsp_i.ack || rsp_i.err;
	assign live_exc = rsp_i.err ? tag_to_exc(rsp_i.tag) : fetch_pkg::EXC_NONE;
	assign req_pc   = {req_i.addr[31:2], 2'b00};

	// First answer seen while frozen gets captured
	assign save_insn = rsp_vld && freeze_i && !saved_q;

	////////////////////////////////////////////////////////////
	// Bypass flag
	////////////////////////////////////////////////////////////

	// Flush opens the window right away
	assign bypass = bypass_q || flush_i;

	// Set by flush, dropped by the first answer after it
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bypass_q <= 1'b0;
		end else if (flush_i) begin
			bypass_q <= 1'b1;
		end else if (rsp_vld) begin
			bypass_q <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Saved entry
	////////////////////////////////////////////////////////////

	// Saved flag, cleared on flush or once unfrozen
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			saved_q <= 1'b0;
		end else if (flush_i) begin
			saved_q <= 1'b0;
		end else if (save_insn) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			saved_q <= 1'b0;
		end
	end

	// Payload, empties back to a NOP slot
	always_ff @(posedge clk) begin
		if (flush_i || (!save_insn && !freeze_i)) begin
			insn_saved_q <= fetch_pkg::NOP_INSN;
			pc_saved_q   <= req_pc;
			exc_saved_q  <= fetch_pkg::EXC_NONE;
		end else if (save_insn) begin
			// Errored or bypassed answers never carry real code
			insn_saved_q <= (rsp_i.err || bypass) ? fetch_pkg::NOP_INSN : rsp_i.data;
			pc_saved_q   <= req_pc;
			exc_saved_q  <= live_exc;
		end
	end

	////////////////////////////////////////////////////////////
	// Output select
	////////////////////////////////////////////////////////////

	always_comb begin
		// Instruction, kill cases first
		if (no_more_dslot_i || rfe_i || bypass) begin
			if_out_o.insn = fetch_pkg::NOP_INSN;
		end else if (saved_q) begin
			if_out_o.insn = insn_saved_q;
		end else if (rsp_i.ack) begin
			if_out_o.insn = rsp_i.data;
		end else if (rsp_i.err) begin
			if_out_o.insn = fetch_pkg::NOP_INSN;
		end else begin
			if_out_o.insn = fetch_pkg::NOP_EMPTY;
		end

		// Address of the slot shown
		if_out_o.pc = saved_q ? pc_saved_q : req_pc;

		// Exception, never raised in a killed delay slot
		if (no_more_dslot_i) begin
			if_out_o.exc = fetch_pkg::EXC_NONE;
		end else if (saved_q) begin
			if_out_o.exc = exc_saved_q;
		end else begin
			if_out_o.exc = live_exc;
		end
	end

	// Nothing to hand over yet
	assign if_stall_o = !rsp_vld && !saved_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$SIM_LOG"

verilator --binary --timing --assert --top-module fetch_tb \
	-f fetch_unit.f -Mdir obj_dir -o fetch_sim > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/fetch_sim > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "RESULT: FAIL" "$SIM_LOG" && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" "$SIM_LOG" || { echo "simulation ended early"; exit 1; }
exit 0

// ==== verification/fetch_sva.sv ====
////////////////////////////////////////////////////////////
// Fetch stage assertions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_sva (
	input wire             clk,
	input wire             rst_n_i,
	input wire             flush_i,
	input wire             freeze_i,
	input wire             no_more_dslot_i,
	input wire             saved_i,
	input fetch_pkg::exc_e exc_i,
	input wire [31:0]      addr_i
);

	// Flush empties the saved slot
	a_flush_clears_saved: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		flush_i |=> !saved_i
	) else $error("saved flag still set after flush");

	// Killed delay slot never raises an exception
	a_dslot_no_exc: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		no_more_dslot_i |-> (exc_i == fetch_pkg::EXC_NONE)
	) else $error("exception raised with no_more_dslot");

	// Address held while frozen, unless redirected
	a_addr_stable: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(freeze_i && !flush_i) |=> $stable(addr_i)
	) else $error("fetch address moved during freeze");

endmodule

bind if_stage fetch_sva u_fetch_sva (
	.clk             (clk),
	.rst_n_i         (rst_n_i),
	.flush_i         (flush_i),
	.freeze_i        (freeze_i),
	.no_more_dslot_i (no_more_dslot_i),
	.saved_i         (saved_q),
	.exc_i           (if_out_o.exc),
	.addr_i          (req_i.addr)
);

`default_nettype wire

// ==== verification/fetch_tb.sv ====
////////////////////////////////////////////////////////////
// Fetch unit testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	// Deliveries per test
	localparam int N_SEQ    = 40;
	localparam int N_FREEZE = 60;
	localparam int N_FLUSH  = 60;
	localparam int N_ERR    = 60;
	localparam int N_KILL   = 40;
	localparam int N_TOTAL  = N_SEQ + N_FREEZE + N_FLUSH + N_ERR + N_KILL;
	// Freeze and flush stretch the per delivery worst case of max latency plus one
	localparam int MAX_LAT     = 3;
	localparam int SLACK       = 3;
	localparam int CYCLE_LIMIT = N_TOTAL * (MAX_LAT + 1) * SLACK + 20;

	logic                 clk;
	logic                 rst_n_i;
	logic                 freeze_i;
	logic                 flush_i;
	logic [31:0]          flush_pc_i;
	logic                 no_more_dslot_i;
	logic                 rfe_i;
	fetch_pkg::icpu_req_t icpu_req;
	fetch_pkg::icpu_rsp_t icpu_rsp;
	fetch_pkg::if_out_t   if_out;
	logic                 if_stall;

	// Cache model state
	logic                 ack_q;
	logic                 err_q;
	fetch_pkg::itag_e     tag_q;
	int                   wait_cnt;

	// Stimulus knob probabilities out of 16
	logic [3:0]           freeze_k;
	logic [3:0]           flush_k;
	logic [3:0]           kill_k;
	logic [3:0]           rfe_k;
	logic [3:0]           err_k;

	// Reference model state
	logic                 valid_m;
	logic                 sv_m;
	logic [31:0]          sv_insn_m;
	logic [31:0]          sv_pc_m;
	fetch_pkg::exc_e      sv_exc_m;
	logic                 byp_m;
	logic [31:0]          pc_m;
	logic [31:0]          dlv_pc;
	int                   dlv_count;

	integer               seed = 8;
	int                   errors = 0;
	int                   checks = 0;
	int                   tests = 0;
	int                   cyc = 0;
	logic                 checking;

	fetch_top uut (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.icpu_req_o      (icpu_req),
		.icpu_rsp_i      (icpu_rsp),
		.freeze_i        (freeze_i),
		.flush_i         (flush_i),
		.flush_pc_i      (flush_pc_i),
		.no_more_dslot_i (no_more_dslot_i),
		.rfe_i           (rfe_i),
		.if_out_o        (if_out),
		.if_stall_o      (if_stall)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference functions
	////////////////////////////////////////////////////////////

	// Memory contents as a scramble of the full address
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
	endfunction

	function automatic fetch_pkg::exc_e exc_of(input fetch_pkg::itag_e t);
		fetch_pkg::exc_e e;
		case (t)
			fetch_pkg::ITAG_TE: e = fetch_pkg::EXC_ITLB_MISS;
			fetch_pkg::ITAG_PE: e = fetch_pkg::EXC_IMMU_FAULT;
			fetch_pkg::ITAG_BE: e = fetch_pkg::EXC_IBUS_ERR;
			default:            e = fetch_pkg::EXC_NONE;
		endcase
		return e;
	endfunction

	// Expected decode slot from the response and the saved copy
	function automatic fetch_pkg::if_out_t ref_out(
		input fetch_pkg::icpu_rsp_t rsp,
		input logic                 flush,
		input logic                 kill,
		input logic                 rfe,
		input logic                 sv,
		input logic [31:0]          sv_insn,
		input logic [31:0]          sv_pc,
		input fetch_pkg::exc_e      sv_exc,
		input logic                 byp,
		input logic [31:0]          pc
	);
		fetch_pkg::if_out_t o;
		if (kill || rfe || byp || flush) begin
			o.insn = fetch_pkg::NOP_INSN;
		end else if (sv) begin
			o.insn = sv_insn;
		end else if (rsp.ack) begin
			o.insn = rsp.data;
		end else if (rsp.err) begin
			o.insn = fetch_pkg::NOP_INSN;
		end else begin
			o.insn = fetch_pkg::NOP_EMPTY;
		end
		o.pc = sv ? sv_pc : pc;
		if (kill) begin
			o.exc = fetch_pkg::EXC_NONE;
		end else if (sv) begin
			o.exc = sv_exc;
		end else if (rsp.err) begin
			o.exc = exc_of(rsp.tag);
		end else begin
			o.exc = fetch_pkg::EXC_NONE;
		end
		return o;
	endfunction

	// Response bus with data following the current address
	always_comb begin
		icpu_rsp.ack  = ack_q;
		icpu_rsp.err  = err_q;
		icpu_rsp.tag  = tag_q;
		icpu_rsp.data = err_q ? ~mem_word(icpu_req.addr) : mem_word(icpu_req.addr);
	end

	////////////////////////////////////////////////////////////
	// Stimulus, cache model and model state
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin : drive_and_track
		logic        rsp_vld;
		logic        stall;
		logic        adv;
		logic        byp_eff;
		logic        reload;
		int          cnt;
		logic [31:0] r;
		rsp_vld = ack_q || err_q;
		stall   = !rsp_vld && !sv_m;
		adv     = !freeze_i && !stall;
		byp_eff = byp_m || flush_i;
		r       = $random(seed);
		if (!rst_n_i) begin
			ack_q    <= 1'b0;
			err_q    <= 1'b0;
			tag_q    <= fetch_pkg::ITAG_NONE;
			wait_cnt <= 0;
			valid_m  <= 1'b0;
			sv_m     <= 1'b0;
			byp_m    <= 1'b0;
			pc_m     <= fetch_pkg::RESET_PC;
			dlv_pc   <= fetch_pkg::RESET_PC;
		end else begin
			// Random control inputs
			freeze_i        <= (r[3:0] < freeze_k);
			flush_i         <= (r[7:4] < flush_k);
			no_more_dslot_i <= (r[11:8] < kill_k);
			rfe_i           <= (r[15:12] < rfe_k);
			flush_pc_i      <= 32'h0000_2000 + {20'h0, r[27:16]};
			valid_m         <= 1'b1;

			// Saved copy of the first answer under freeze
			if (flush_i) begin
				sv_m <= 1'b0;
			end else if (rsp_vld && freeze_i && !sv_m) begin
				sv_m      <= 1'b1;
				sv_insn_m <= (err_q || byp_eff) ? fetch_pkg::NOP_INSN : icpu_rsp.data;
				sv_pc_m   <= pc_m;
				sv_exc_m  <= err_q ? exc_of(tag_q) : fetch_pkg::EXC_NONE;
			end else if (!freeze_i) begin
				sv_m <= 1'b0;
			end

			if (flush_i) begin
				byp_m <= 1'b1;
			end else if (rsp_vld) begin
				byp_m <= 1'b0;
			end

			// Count deliveries and step the expected pc
			if (adv && !flush_i) begin
				dlv_count <= dlv_count + 1;
				dlv_pc    <= dlv_pc + 32'd4;
			end

			// Program counter
			if (flush_i) begin
				pc_m   <= {flush_pc_i[31:2], 2'b00};
				dlv_pc <= {flush_pc_i[31:2], 2'b00};
			end else if (adv) begin
				pc_m <= pc_m + 32'd4;
			end

			// Cache answer after 0 to 3 idle cycles
			reload = flush_i || adv || rsp_vld;
			cnt    = reload ? int'(r[29:28]) : wait_cnt;
			if (cnt == 0) begin
				wait_cnt <= 0;
				if (r[27:24] < err_k) begin
					ack_q <= 1'b0;
					err_q <= 1'b1;
					case (r[23:22])
						2'd1:    tag_q <= fetch_pkg::ITAG_PE;
						2'd2:    tag_q <= fetch_pkg::ITAG_TE;
						default: tag_q <= fetch_pkg::ITAG_BE;
					endcase
				end else begin
					ack_q <= 1'b1;
					err_q <= 1'b0;
					tag_q <= fetch_pkg::ITAG_NONE;
				end
			end else begin
				ack_q    <= 1'b0;
				err_q    <= 1'b0;
				tag_q    <= fetch_pkg::ITAG_NONE;
				wait_cnt <= cnt - 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare at mid cycle where everything is settled
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin : compare
		fetch_pkg::if_out_t exp;
		logic               exp_stall;
		logic               deliver;
		if (rst_n_i && checking) begin
			exp = ref_out(icpu_rsp, flush_i, no_more_dslot_i, rfe_i, sv_m, sv_insn_m,
				sv_pc_m, sv_exc_m, byp_m, pc_m);
			exp_stall = !(icpu_rsp.ack || icpu_rsp.err) && !sv_m;
			// Slot handed to decode at the coming edge
			deliver = !freeze_i && !exp_stall && !flush_i;
			checks++;
			assert (if_out.insn == exp.insn) else begin
				$display("mismatch if_out_o.insn: got %h exp %h", if_out.insn, exp.insn);
				errors++;
			end
			assert (if_out.pc == exp.pc) else begin
				$display("mismatch if_out_o.pc: got %h exp %h", if_out.pc, exp.pc);
				errors++;
			end
			assert (if_out.exc == exp.exc) else begin
				$display("mismatch if_out_o.exc: got %h exp %h", if_out.exc, exp.exc);
				errors++;
			end
			assert (if_stall == exp_stall) else begin
				$display("mismatch if_stall_o: got %h exp %h", if_stall, exp_stall);
				errors++;
			end
			assert (icpu_req.addr == pc_m) else begin
				$display("mismatch icpu_req_o.addr: got %h exp %h", icpu_req.addr, pc_m);
				errors++;
			end
			assert (icpu_req.valid == valid_m) else begin
				$display("mismatch icpu_req_o.valid: got %h exp %h", icpu_req.valid, valid_m);
				errors++;
			end
			// Each address delivered once and in order
			if (deliver) begin
				assert (if_out.pc == dlv_pc) else begin
					$display("mismatch delivered if_out_o.pc: got %h exp %h",
						if_out.pc, dlv_pc);
					errors++;
				end
			end
		end
	end

	// Cycle watchdog
	always @(posedge clk) begin : watchdog
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	// State while reset is held
	task automatic check_reset();
		assert (icpu_req.valid == 1'b0) else begin
			$display("mismatch icpu_req_o.valid: got %h exp %h", icpu_req.valid, 1'b0);
			errors++;
		end
		assert (if_out.exc == fetch_pkg::EXC_NONE) else begin
			$display("mismatch if_out_o.exc: got %h exp %h", if_out.exc,
				fetch_pkg::EXC_NONE);
			errors++;
		end
		assert (if_stall == 1'b1) else begin
			$display("mismatch if_stall_o: got %h exp %h", if_stall, 1'b1);
			errors++;
		end
		assert (if_out.insn == fetch_pkg::NOP_EMPTY) else begin
			$display("mismatch if_out_o.insn: got %h exp %h", if_out.insn,
				fetch_pkg::NOP_EMPTY);
			errors++;
		end
		tests++;
		$display("test reset: done, errors so far %0d", errors);
	endtask

	// Run until n more deliveries with the given knobs
	task automatic run_test(input string name, input int n, input logic [3:0] fk,
		input logic [3:0] flk, input logic [3:0] kk, input logic [3:0] rk,
		input logic [3:0] ek);
		int start_err;
		int start_dlv;
		@(negedge clk);
		start_err = errors;
		start_dlv = dlv_count;
		freeze_k  = fk;
		flush_k   = flk;
		kill_k    = kk;
		rfe_k     = rk;
		err_k     = ek;
		while (dlv_count - start_dlv < n) begin
			@(negedge clk);
		end
		tests++;
		$display("test %s: %0d deliveries, %0d errors", name, n, errors - start_err);
	endtask

	initial begin
		clk             = 1'b0;
		rst_n_i         = 1'b0;
		freeze_i        = 1'b0;
		flush_i         = 1'b0;
		flush_pc_i      = 32'h0;
		no_more_dslot_i = 1'b0;
		rfe_i           = 1'b0;
		freeze_k        = 4'd0;
		flush_k         = 4'd0;
		kill_k          = 4'd0;
		rfe_k           = 4'd0;
		err_k           = 4'd0;
		dlv_count       = 0;
		checking        = 1'b0;

		// Two reset edges
		@(posedge clk);
		@(negedge clk);
		check_reset();
		@(posedge clk);
		rst_n_i <= 1'b1;
		checking = 1'b1;
		@(negedge clk);

		run_test("sequential", N_SEQ, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0);
		run_test("freeze", N_FREEZE, 4'd6, 4'd0, 4'd0, 4'd0, 4'd0);
		run_test("flush", N_FLUSH, 4'd3, 4'd2, 4'd0, 4'd0, 4'd0);
		run_test("error tags", N_ERR, 4'd5, 4'd0, 4'd0, 4'd0, 4'd6);
		run_test("kill and rfe", N_KILL, 4'd3, 4'd0, 4'd5, 4'd5, 4'd4);

		$display("summary: tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
